//--- rtl/rotator_pkg.sv
package rotator_pkg;

  // Beat geometry.
  localparam int word_width = 8;
  localparam int lanes      = 4;
  localparam int data_width = word_width * lanes;

  // Largest kernel and channel counts a bank must hold.
  localparam int kw_max     = 3;
  localparam int cin_max    = 8;
  localparam int bank_depth = kw_max * cin_max;
  localparam int addr_bits  = $clog2(bank_depth);

  // Replays of one kernel set.
  localparam int reps_max = 16;

  // Counter widths for the config fields.
  localparam int kw_bits   = $clog2(kw_max);
  localparam int cin_bits  = $clog2(cin_max);
  localparam int reps_bits = $clog2(reps_max);

  // Config beat from the low bits of its data.
  typedef struct packed {
    logic [kw_bits-1:0]   kw_1;
    logic [cin_bits-1:0]  cin_1;
    logic [reps_bits-1:0] reps_1;
  } rot_cfg_t;

  localparam int cfg_bits = $bits(rot_cfg_t);

  // Sideband that travels with every output beat.
  typedef struct packed {
    logic [kw_bits-1:0] kw_1;
    logic               first_pass;
    logic               cin_last;
    logic               pass_end;
  } rot_user_t;

  // One output beat of a bank.
  typedef struct packed {
    logic [data_width-1:0] data;
    rot_user_t             user;
    logic                  last;
  } bank_out_t;

  // Bank life cycle.
  typedef enum logic [1:0] {
    bank_empty,
    bank_fill,
    bank_full,
    bank_drain
  } bank_state_e;

endpackage

//--- rtl/weight_bank.sv
module weight_bank import rotator_pkg::*; (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  input  logic                  wr_last,
  input  logic [data_width-1:0] wr_data,
  output logic                  wr_ready,
  input  logic                  rd_ready,
  output logic                  rd_valid,
  output bank_out_t             rd_beat
);

  bank_state_e state;
  rot_cfg_t    cfg;

  logic [data_width-1:0] mem [bank_depth];
  logic [addr_bits-1:0]  wr_addr;
  logic [addr_bits-1:0]  rd_addr;

  // Drain position.
  logic [kw_bits-1:0]   col;
  logic [cin_bits-1:0]  ch;
  logic [reps_bits-1:0] pass;
  logic                 issue_done;

  // Memory read stage.
  logic                  fetch_vld;
  logic [data_width-1:0] mem_q;
  rot_user_t             fetch_user;
  logic                  fetch_last;

  // Output register.
  logic      out_vld;
  bank_out_t out_beat;

  logic wr_fire;
  logic out_xfer;
  logic load_out;
  logic rd_en;
  logic col_end;
  logic ch_end;
  logic pass_end;
  logic last_pass;

  assign wr_ready = (state == bank_empty) || (state == bank_fill);
  assign wr_fire  = wr_valid && wr_ready;

  assign out_xfer = out_vld && rd_ready;
  assign load_out = fetch_vld && (!out_vld || out_xfer);

  // Fetch only when the read stage will be free next cycle.
  assign rd_en = (state == bank_drain) && !issue_done && (!fetch_vld || load_out);

  assign col_end   = (col == cfg.kw_1);
  assign ch_end    = (ch == cfg.cin_1);
  assign pass_end  = col_end && ch_end;
  assign last_pass = (pass == cfg.reps_1);

  assign rd_valid = out_vld;
  assign rd_beat  = out_beat;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state   <= bank_empty;
      cfg     <= '0;
      wr_addr <= '0;
    end else begin
      case (state)
        bank_empty: begin
          if (wr_fire) begin
            cfg     <= rot_cfg_t'(wr_data[cfg_bits-1:0]);
            wr_addr <= '0;
            state   <= bank_fill;
          end
        end
        bank_fill: begin
          if (wr_fire) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_last) begin
              state <= bank_full;
            end
          end
        end
        bank_full: begin
          // Wait for this bank's read turn.
          if (rd_ready) begin
            state <= bank_drain;
          end
        end
        bank_drain: begin
          if (out_xfer && out_beat.last) begin
            state <= bank_empty;
          end
        end
        default: state <= bank_empty;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if ((state == bank_fill) && wr_fire) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Walk columns inside channels inside passes.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_addr    <= '0;
      col        <= '0;
      ch         <= '0;
      pass       <= '0;
      issue_done <= 1'b0;
    end else if (state == bank_full) begin
      rd_addr    <= '0;
      col        <= '0;
      ch         <= '0;
      pass       <= '0;
      issue_done <= 1'b0;
    end else if (rd_en) begin
      if (pass_end) begin
        rd_addr <= '0;
        col     <= '0;
        ch      <= '0;
        pass    <= pass + 1'b1;
        if (last_pass) begin
          issue_done <= 1'b1;
        end
      end else begin
        rd_addr <= rd_addr + 1'b1;
        if (col_end) begin
          col <= '0;
          ch  <= ch + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      fetch_vld <= 1'b0;
    end else if (rd_en) begin
      fetch_vld <= 1'b1;
    end else if (load_out) begin
      fetch_vld <= 1'b0;
    end
  end

  // Flags ride along with the memory read.
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      mem_q                 <= mem[rd_addr];
      fetch_user.kw_1       <= cfg.kw_1;
      fetch_user.first_pass <= (pass == '0);
      fetch_user.cin_last   <= ch_end;
      fetch_user.pass_end   <= pass_end;
      fetch_last            <= pass_end && last_pass;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else if (load_out) begin
      out_vld <= 1'b1;
    end else if (out_xfer) begin
      out_vld <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_out) begin
      out_beat.data <= mem_q;
      out_beat.user <= fetch_user;
      out_beat.last <= fetch_last;
    end
  end

endmodule

//--- rtl/bank_sched.sv
module bank_sched import rotator_pkg::*; (
  input  logic                  aclk,
  input  logic                  rst_n,

  // Input stream.
  input  logic                  s_valid,
  input  logic                  s_last,
  input  logic [data_width-1:0] s_data,
  output logic                  s_ready,

  // Output stream.
  input  logic                  m_ready,
  output logic                  m_valid,
  output bank_out_t             m_beat,

  // Bank write side.
  output logic [1:0]            wr_valid,
  output logic [1:0]            wr_last,
  output logic [data_width-1:0] wr_data,
  input  logic [1:0]            wr_ready,

  // Bank read side.
  input  logic [1:0]            rd_valid,
  input  bank_out_t [1:0]       rd_beat,
  output logic [1:0]            rd_ready
);

  logic wr_turn;
  logic rd_turn;
  logic ready_en;

  logic s_fire;
  logic m_fire;

  // Input stays closed for the first cycle out of reset.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  assign s_ready = ready_en && wr_ready[wr_turn];
  assign s_fire  = s_valid && s_ready;

  assign m_valid = rd_valid[rd_turn];
  assign m_beat  = rd_beat[rd_turn];
  assign m_fire  = m_valid && m_ready;

  // Write side steering.
  always_comb begin
    wr_valid = '0;
    wr_last  = '0;
    wr_valid[wr_turn] = s_valid && ready_en;
    wr_last[wr_turn]  = s_last;
  end

  assign wr_data = s_data;

  // Only the bank whose turn it is sees m_ready.
  always_comb begin
    rd_ready = '0;
    rd_ready[rd_turn] = m_ready;
  end

  // Write turn flips at the end of each input packet.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_turn <= 1'b0;
    end else if (s_fire && s_last) begin
      wr_turn <= ~wr_turn;
    end
  end

  // Read turn flips after the final replayed beat.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_turn <= 1'b0;
    end else if (m_fire && m_beat.last) begin
      rd_turn <= ~rd_turn;
    end
  end

endmodule

//--- rtl/weight_rotator.sv
module weight_rotator import rotator_pkg::*; (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  s_valid,
  input  logic                  s_last,
  input  logic [data_width-1:0] s_data,
  output logic                  s_ready,
  input  logic                  m_ready,
  output logic                  m_valid,
  output bank_out_t             m_beat
);

  logic [1:0]            wr_valid;
  logic [1:0]            wr_last;
  logic [data_width-1:0] wr_data;
  logic [1:0]            wr_ready;
  logic [1:0]            rd_valid;
  bank_out_t [1:0]       rd_beat;
  logic [1:0]            rd_ready;

  // Ping bank.
  weight_bank i_bank0 (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .wr_valid (wr_valid[0]),
    .wr_last  (wr_last[0]),
    .wr_data  (wr_data),
    .wr_ready (wr_ready[0]),
    .rd_ready (rd_ready[0]),
    .rd_valid (rd_valid[0]),
    .rd_beat  (rd_beat[0])
  );

  // Pong bank.
  weight_bank i_bank1 (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .wr_valid (wr_valid[1]),
    .wr_last  (wr_last[1]),
    .wr_data  (wr_data),
    .wr_ready (wr_ready[1]),
    .rd_ready (rd_ready[1]),
    .rd_valid (rd_valid[1]),
    .rd_beat  (rd_beat[1])
  );

  bank_sched i_bank_sched (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_valid  (s_valid),
    .s_last   (s_last),
    .s_data   (s_data),
    .s_ready  (s_ready),
    .m_ready  (m_ready),
    .m_valid  (m_valid),
    .m_beat   (m_beat),
    .wr_valid (wr_valid),
    .wr_last  (wr_last),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .rd_valid (rd_valid),
    .rd_beat  (rd_beat),
    .rd_ready (rd_ready)
  );

endmodule

//--- test/weight_rotator_tb.sv
module weight_rotator_tb import rotator_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 8;

  logic                  aclk = 1'b0;
  logic                  rst_n;
  logic                  s_valid;
  logic                  s_last;
  logic [data_width-1:0] s_data;
  logic                  s_ready;
  logic                  m_ready;
  logic                  m_valid;
  bank_out_t             m_beat;

  logic [31:0]           lcg_state = 32'd1;
  rot_cfg_t              cfg_q[$];
  logic [data_width-1:0] word_q[$];
  logic [data_width-1:0] in_data[$];
  logic                  in_last[$];
  bank_out_t             exp_q[$];

  int total_beats = 0;
  int checks      = 0;
  int errors      = 0;
  int test_errors = 0;
  int test_beats  = 0;
  int tests_run   = 0;

  weight_rotator i_weight_rotator (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat)
  );

  always #(clk_period / 2) aclk = ~aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Config word first, then kw*cin weights.
  function automatic void make_packet(input bit full_size);
    rot_cfg_t              cfg;
    logic [data_width-1:0] word;
    int                    n;
    if (full_size) begin
      cfg.kw_1   = kw_bits'(kw_max - 1);
      cfg.cin_1  = cin_bits'(cin_max - 1);
      cfg.reps_1 = reps_bits'(2);
    end else begin
      cfg.kw_1   = kw_bits'(rand_below(kw_max));
      cfg.cin_1  = cin_bits'(rand_below(cin_max));
      cfg.reps_1 = reps_bits'(rand_below(reps_max));
    end
    word = lcg_next();
    word[$bits(rot_cfg_t)-1:0] = cfg;
    cfg_q.push_back(cfg);
    word_q.push_back(word);
    n = (int'(cfg.kw_1) + 1) * (int'(cfg.cin_1) + 1);
    for (int i = 0; i < n; i++) begin
      word_q.push_back(lcg_next());
    end
    total_beats += 1 + n + n * (int'(cfg.reps_1) + 1);
  endfunction

  task automatic load_packets(input int count);
    rot_cfg_t              cfg;
    logic [data_width-1:0] w[$];
    bank_out_t             b;
    int                    kw;
    int                    cin;
    int                    reps;
    in_data.delete();
    in_last.delete();
    for (int pk = 0; pk < count; pk++) begin
      cfg  = cfg_q.pop_front();
      kw   = int'(cfg.kw_1) + 1;
      cin  = int'(cfg.cin_1) + 1;
      reps = int'(cfg.reps_1) + 1;
      in_data.push_back(word_q.pop_front());
      in_last.push_back(1'b0);
      w.delete();
      for (int i = 0; i < kw * cin; i++) begin
        w.push_back(word_q.pop_front());
        in_data.push_back(w[i]);
        in_last.push_back(i == kw * cin - 1);
      end
      // Each pass walks the channel groups of kw beats.
      for (int p = 0; p < reps; p++) begin
        for (int c = 0; c < cin; c++) begin
          for (int k = 0; k < kw; k++) begin
            b.data            = w[c * kw + k];
            b.user.kw_1       = cfg.kw_1;
            b.user.first_pass = (p == 0);
            b.user.cin_last   = (c == cin - 1);
            b.user.pass_end   = (c == cin - 1) && (k == kw - 1);
            b.last            = b.user.pass_end && (p == reps - 1);
            exp_q.push_back(b);
          end
        end
      end
    end
  endtask

  // Drives input and checks output once per negedge.
  task automatic stream_packets(input string name, input int gap_pct, input int stall_pct,
                                input int stop_after);
    int        idx;
    int        got;
    logic      pending;
    logic      held_stall;
    bank_out_t held_beat;
    bank_out_t want;
    idx        = 0;
    got        = 0;
    pending    = 1'b0;
    held_stall = 1'b0;
    held_beat  = '0;
    while ((idx < in_data.size() || exp_q.size() > 0) &&
           (stop_after < 0 || got < stop_after)) begin
      @(negedge aclk);
      if (idx < in_data.size()) begin
        if (pending || rand_below(100) >= gap_pct) begin
          s_valid = 1'b1;
          s_data  = in_data[idx];
          s_last  = in_last[idx];
        end else begin
          s_valid = 1'b0;
        end
        pending = s_valid && !s_ready;
        if (s_valid && s_ready) begin
          idx++;
        end
      end else begin
        s_valid = 1'b0;
      end
      // A stalled beat must not move.
      if (held_stall) begin
        check_value({name, " held valid"}, 64'd1, 64'(m_valid));
        check_value({name, " held beat"}, 64'(held_beat), 64'(m_beat));
      end
      m_ready = (rand_below(100) >= stall_pct);
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          test_errors++;
          $display("Test %s produced an output beat that no packet accounts for", name);
        end else begin
          want = exp_q.pop_front();
          check_value({name, " data"}, 64'(want.data), 64'(m_beat.data));
          check_value({name, " user"}, 64'(want.user), 64'(m_beat.user));
          check_value({name, " last"}, 64'(want.last), 64'(m_beat.last));
          got++;
          test_beats++;
        end
      end
      held_stall = m_valid && !m_ready;
      held_beat  = m_beat;
    end
  endtask

  task automatic finish_test(input string name);
    @(negedge aclk);
    s_valid = 1'b0;
    m_ready = 1'b0;
    repeat (4) @(negedge aclk);
    check_value({name, " idle valid"}, 64'd0, 64'(m_valid));
    tests_run++;
    $display("Test %s done: %0d beats, %0d mismatches", name, test_beats, test_errors);
  endtask

  task automatic run_test(input string name, input int count, input int gap_pct,
                          input int stall_pct);
    test_errors = 0;
    test_beats  = 0;
    load_packets(count);
    stream_packets(name, gap_pct, stall_pct, -1);
    finish_test(name);
  endtask

  task automatic reset_during_drain();
    test_errors = 0;
    test_beats  = 0;
    load_packets(1);
    stream_packets("reset_during_drain", 0, 0, 3);
    rst_n   = 1'b0;
    s_valid = 1'b0;
    m_ready = 1'b0;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;
    check_value("reset_during_drain m_valid", 64'd0, 64'(m_valid));
    check_value("reset_during_drain s_ready", 64'd0, 64'(s_ready));
    exp_q.delete();
    load_packets(1);
    stream_packets("reset_during_drain", 0, 25, -1);
    finish_test("reset_during_drain");
  endtask

  initial begin
    int timeout_ns;
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    m_ready = 1'b0;
    // Stimulus for every test in test order.
    make_packet(1'b0);
    make_packet(1'b1);
    for (int i = 0; i < 32; i++) begin
      make_packet(1'b0);
    end
    make_packet(1'b1);
    make_packet(1'b0);
    timeout_ns = 4 * total_beats * clk_period + 2000;
    fork
      begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
      end
    join_none
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;
    run_test("single_packet", 1, 0, 0);
    run_test("full_size_sideband", 1, 0, 0);
    run_test("back_to_back", 20, 0, 0);
    run_test("backpressure", 6, 0, 40);
    run_test("gaps_and_backpressure", 6, 30, 40);
    reset_during_drain();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
rtl/rotator_pkg.sv
rtl/weight_bank.sv
rtl/bank_sched.sv
rtl/weight_rotator.sv
test/weight_rotator_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the weight rotator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 -f verilog.f --top-module weight_rotator_tb \
  -o weight_rotator_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/weight_rotator_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$log"; then
  exit 0
fi
exit 1
